// ==== src/sw_cfg_pkg.sv ====
`default_nettype none

package sw_cfg_pkg;

    // sequence limits
    localparam int REF_MAX_LEN  = 16;
    localparam int READ_MAX_LEN = 16;

    localparam int LEN_W      = 5;  // 1-based length, up to 16
    localparam int REF_IDX_W  = 4;  // 0-based column
    localparam int READ_IDX_W = 4;  // 0-based row

    // signed cell score
    localparam int SCORE_W = 10;

    // affine gap scoring
    localparam logic signed [SCORE_W-1:0] MATCH_SCORE    = 10'sd1;
    localparam logic signed [SCORE_W-1:0] MISMATCH_SCORE = -10'sd4;
    localparam logic signed [SCORE_W-1:0] GAP_OPEN       = -10'sd6;
    localparam logic signed [SCORE_W-1:0] GAP_EXTEND     = -10'sd1;

endpackage

`default_nettype wire

// ==== src/sw_types_pkg.sv ====
`default_nettype none

package sw_types_pkg;

    import sw_cfg_pkg::*;

    typedef logic [1:0] sw_base_t;  // A=0 C=1 G=2 T=3

    typedef logic signed [SCORE_W-1:0] sw_score_t;

    // first base sits in the top pair
    typedef struct packed {
        sw_base_t [REF_MAX_LEN-1:0]  ref_seq;
        sw_base_t [READ_MAX_LEN-1:0] read_seq;
        logic [LEN_W-1:0]            ref_len;
        logic [LEN_W-1:0]            read_len;
    } sw_job_t;

    typedef struct packed {
        logic                 valid;
        sw_base_t             base;
        logic [REF_IDX_W-1:0] col;
    } sw_ref_stream_t;

    typedef struct packed {
        logic                 valid;
        sw_score_t            h;
        sw_score_t            e;  // gap along the reference
        sw_score_t            f;  // gap along the read
        logic [REF_IDX_W-1:0] col;
    } sw_cell_t;

    typedef struct packed {
        sw_score_t             score;
        logic [READ_IDX_W-1:0] row;
        logic [REF_IDX_W-1:0]  col;
    } sw_result_t;

    // index r holds row r
    typedef sw_base_t [READ_MAX_LEN-1:0] sw_read_bases_t;
    typedef sw_cell_t [READ_MAX_LEN-1:0] sw_cells_t;

endpackage

`default_nettype wire

// ==== src/sw_pe.sv ====
`timescale 1ns/100ps
`default_nettype none

module sw_pe (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         i_clear,
    input  wire sw_types_pkg::sw_ref_stream_t i_ref,
    input  wire sw_types_pkg::sw_base_t i_read_base,
    input  wire sw_types_pkg::sw_cell_t i_top,
    output sw_types_pkg::sw_ref_stream_t o_ref,
    output sw_types_pkg::sw_cell_t      o_cell
);

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    sw_ref_stream_t ref_q;
    sw_cell_t       cell_q;
    sw_cell_t       cell_d;
    sw_score_t      diag_q;     // top H one column back
    sw_score_t      sub_score;
    sw_score_t      e_new;
    sw_score_t      f_new;
    sw_score_t      h_new;

    function automatic sw_score_t max2(input sw_score_t a, input sw_score_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        sub_score = (i_ref.base == i_read_base) ? MATCH_SCORE : MISMATCH_SCORE;

        // left neighbour is this cell's previous column
        e_new = max2(cell_q.h + GAP_OPEN, cell_q.e + GAP_EXTEND);
        e_new = max2(e_new, '0);
        f_new = max2(i_top.h + GAP_OPEN, i_top.f + GAP_EXTEND);
        f_new = max2(f_new, '0);

        h_new = max2('0, diag_q + sub_score);
        h_new = max2(h_new, max2(e_new, f_new));

        cell_d = cell_q;
        cell_d.valid = 1'b0;    // hold scores when no base passes
        if (i_ref.valid) begin
            cell_d.valid = 1'b1;
            cell_d.h = h_new;
            cell_d.e = e_new;
            cell_d.f = f_new;
            cell_d.col = i_ref.col;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ref_q <= '0;
            cell_q <= '0;
            diag_q <= '0;
        end else if (i_clear) begin
            ref_q <= '0;    // also kills a wave left from the last job
            cell_q <= '0;
            diag_q <= '0;
        end else begin
            ref_q <= i_ref;
            cell_q <= cell_d;
            diag_q <= i_top.h;
        end
    end

    assign o_ref = ref_q;
    assign o_cell = cell_q;

endmodule

`default_nettype wire

// ==== src/sw_pe_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module sw_pe_array (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 i_clear,
    input  wire sw_types_pkg::sw_ref_stream_t   i_ref,
    input  wire sw_types_pkg::sw_read_bases_t   i_read_bases,
    output sw_types_pkg::sw_cells_t             o_cells
);

    import sw_types_pkg::*;

    // reference leaving each row, one cycle behind its input
    sw_ref_stream_t [$size(sw_cells_t)-1:0] ref_link;

    for (genvar r = 0; r < $size(sw_cells_t); r++) begin : g_row
        sw_ref_stream_t ref_in;
        sw_cell_t       top_in;

        if (r == 0) begin : g_first
            assign ref_in = i_ref;
            assign top_in = '0;     // boundary row above the read
        end else begin : g_chain
            assign ref_in = ref_link[r-1];
            assign top_in = o_cells[r-1];
        end

        sw_pe sw_pe_i (
            .clk         (clk),
            .rst         (rst),
            .i_clear     (i_clear),
            .i_ref       (ref_in),
            .i_read_base (i_read_bases[r]),
            .i_top       (top_in),
            .o_ref       (ref_link[r]),
            .o_cell      (o_cells[r])
        );
    end

endmodule

`default_nettype wire

// ==== src/sw_max_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module sw_max_tracker (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             i_clear,
    input  wire sw_types_pkg::sw_cells_t    i_cells,
    input  wire                             i_scan,
    input  wire [sw_cfg_pkg::LEN_W-1:0]     i_read_len,
    output logic                            o_scan_done,
    output sw_types_pkg::sw_result_t        o_best
);

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    sw_score_t [READ_MAX_LEN-1:0]                 row_h_q;
    sw_score_t [READ_MAX_LEN-1:0]                 row_h_d;
    logic [READ_MAX_LEN-1:0][REF_IDX_W-1:0]       row_col_q;
    logic [READ_MAX_LEN-1:0][REF_IDX_W-1:0]       row_col_d;
    logic [READ_IDX_W-1:0]                        scan_row;
    logic [LEN_W-1:0]                             scan_last;
    sw_result_t                                   best_q;

    // next row maxima, also read by the scan so a cell landing now is seen
    always_comb begin
        row_h_d = row_h_q;
        row_col_d = row_col_q;
        for (int r = 0; r < READ_MAX_LEN; r++) begin
            if (i_cells[r].valid && i_cells[r].h > row_h_q[r]) begin
                row_h_d[r] = i_cells[r].h;
                row_col_d[r] = i_cells[r].col;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_clear) begin
            row_h_q <= '0;
            row_col_q <= '0;
        end else begin
            row_h_q <= row_h_d;
            row_col_q <= row_col_d;
        end
    end

    assign scan_last = i_read_len - 1'b1;
    assign o_scan_done = i_scan && ({1'b0, scan_row} == scan_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            best_q <= '0;
            scan_row <= '0;
        end else if (i_clear) begin
            best_q <= '0;   // score 0 at row 0, column 0
            scan_row <= '0;
        end else if (i_scan) begin
            if (row_h_d[scan_row] > best_q.score) begin    // earlier row wins ties
                best_q.score <= row_h_d[scan_row];
                best_q.row <= scan_row;
                best_q.col <= row_col_d[scan_row];
            end
            scan_row <= o_scan_done ? '0 : scan_row + 1'b1;
        end
    end

    assign o_best = best_q;

endmodule

`default_nettype wire

// ==== src/sw_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module sw_controller (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             i_valid,
    input  wire sw_types_pkg::sw_job_t      i_job,
    input  wire                             i_ready,
    input  wire                             i_scan_done,
    output logic                            o_ready,
    output logic                            o_clear,
    output sw_types_pkg::sw_ref_stream_t    o_ref,
    output sw_types_pkg::sw_read_bases_t    o_read_bases,
    output logic [sw_cfg_pkg::LEN_W-1:0]    o_read_len,
    output logic                            o_scan,
    output logic                            o_valid
);

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_COMPUTE,
        ST_SCAN,
        ST_DONE
    } state_t;

    state_t                     state_q;
    logic [LEN_W:0]             step_q;     // up to ref + read - 2
    logic [LEN_W:0]             last_step;
    sw_base_t [REF_MAX_LEN-1:0] ref_shift;
    sw_read_bases_t             read_q;
    logic [LEN_W-1:0]           ref_len_q;
    logic [LEN_W-1:0]           read_len_q;
    logic                       accept;

    assign accept = (state_q == ST_IDLE) && i_valid;

    // last base reaches the last read row on this step
    assign last_step = {1'b0, ref_len_q} + {1'b0, read_len_q} - 2'd2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
            step_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept)
                        state_q <= ST_LOAD;
                end
                ST_LOAD: begin
                    step_q <= '0;
                    state_q <= ST_COMPUTE;
                end
                ST_COMPUTE: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == last_step)
                        state_q <= ST_SCAN;
                end
                ST_SCAN: begin
                    if (i_scan_done)
                        state_q <= ST_DONE;
                end
                ST_DONE: begin
                    if (i_ready)
                        state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // job registers and reference shifter
    always_ff @(posedge clk) begin
        if (accept) begin
            ref_shift <= i_job.ref_seq;
            ref_len_q <= i_job.ref_len;
            read_len_q <= i_job.read_len;
            for (int r = 0; r < READ_MAX_LEN; r++)
                read_q[r] <= i_job.read_seq[READ_MAX_LEN-1-r];
        end else if (state_q == ST_COMPUTE) begin
            ref_shift <= {ref_shift[REF_MAX_LEN-2:0], 2'b00};
        end
    end

    always_comb begin
        o_ref.valid = (state_q == ST_COMPUTE) && (step_q < {1'b0, ref_len_q});
        o_ref.base = ref_shift[REF_MAX_LEN-1];
        o_ref.col = step_q[REF_IDX_W-1:0];
    end

    assign o_ready = (state_q == ST_IDLE);
    assign o_clear = (state_q == ST_LOAD);
    assign o_scan = (state_q == ST_SCAN);
    assign o_valid = (state_q == ST_DONE);
    assign o_read_bases = read_q;
    assign o_read_len = read_len_q;

endmodule

`default_nettype wire

// ==== src/sw_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sw_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         i_valid,
    input  wire sw_types_pkg::sw_job_t  i_job,
    input  wire                         i_ready,
    output logic                        o_ready,
    output logic                        o_valid,
    output sw_types_pkg::sw_result_t    o_result
);

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    logic               clear;
    sw_ref_stream_t     ref_stream;
    sw_read_bases_t     read_bases;
    logic [LEN_W-1:0]   read_len;
    logic               scan;
    logic               scan_done;
    sw_cells_t          cells;

    sw_controller sw_controller_i (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_job        (i_job),
        .i_ready      (i_ready),
        .i_scan_done  (scan_done),
        .o_ready      (o_ready),
        .o_clear      (clear),
        .o_ref        (ref_stream),
        .o_read_bases (read_bases),
        .o_read_len   (read_len),
        .o_scan       (scan),
        .o_valid      (o_valid)
    );

    sw_pe_array sw_pe_array_i (
        .clk          (clk),
        .rst          (rst),
        .i_clear      (clear),
        .i_ref        (ref_stream),
        .i_read_bases (read_bases),
        .o_cells      (cells)
    );

    sw_max_tracker sw_max_tracker_i (
        .clk          (clk),
        .rst          (rst),
        .i_clear      (clear),
        .i_cells      (cells),
        .i_scan       (scan),
        .i_read_len   (read_len),
        .o_scan_done  (scan_done),
        .o_best       (o_result)    // held until the next load
    );

endmodule

`default_nettype wire

// ==== sim/sw_ref_model.svh ====
`ifndef SW_REF_MODEL_SVH
`define SW_REF_MODEL_SVH

function automatic int larger(input int a, input int b);
    return (a > b) ? a : b;
endfunction

// full affine-gap matrix with a zero boundary in row 0 and column 0
function automatic sw_result_t align_job(input sw_job_t job);
    int h [0:READ_MAX_LEN][0:REF_MAX_LEN];
    int e [0:READ_MAX_LEN][0:REF_MAX_LEN];
    int f [0:READ_MAX_LEN][0:REF_MAX_LEN];
    int sub;
    int best;
    int match_c;
    int mismatch_c;
    int open_c;
    int extend_c;
    sw_result_t res;
    match_c = MATCH_SCORE;
    mismatch_c = MISMATCH_SCORE;
    open_c = GAP_OPEN;
    extend_c = GAP_EXTEND;
    best = 0;
    res = '0;
    for (int i = 0; i <= READ_MAX_LEN; i++) begin
        for (int j = 0; j <= REF_MAX_LEN; j++) begin
            h[i][j] = 0;
            e[i][j] = 0;
            f[i][j] = 0;
        end
    end
    for (int i = 1; i <= int'(job.read_len); i++) begin
        for (int j = 1; j <= int'(job.ref_len); j++) begin
            sub = (job.read_seq[READ_IDX_W'(READ_MAX_LEN - i)] ==
                   job.ref_seq[REF_IDX_W'(REF_MAX_LEN - j)]) ? match_c : mismatch_c;
            e[i][j] = larger(0, larger(h[i][j-1] + open_c, e[i][j-1] + extend_c));
            f[i][j] = larger(0, larger(h[i-1][j] + open_c, f[i-1][j] + extend_c));
            h[i][j] = larger(larger(0, h[i-1][j-1] + sub), larger(e[i][j], f[i][j]));
            if (h[i][j] > best) begin  // first cell in row-major order wins
                best = h[i][j];
                res.score = sw_score_t'(best);
                res.row = READ_IDX_W'(i - 1);
                res.col = REF_IDX_W'(j - 1);
            end
        end
    end
    return res;
endfunction

`endif

// ==== sim/tb_sw_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_sw_top;

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic       clk;
    logic       rst;
    logic       i_valid;
    sw_job_t    i_job;
    logic       i_ready;
    logic       o_ready;
    logic       o_valid;
    sw_result_t o_result;
    integer     seed;

    sw_top sw_top_i (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_valid),
        .i_job    (i_job),
        .i_ready  (i_ready),
        .o_ready  (o_ready),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_result(input string test, input sw_result_t exp,
                                  input sw_result_t act);
        if (act !== exp) begin
            $display("error %s: expected score %0d row %0d col %0d, got score %0d row %0d col %0d",
                     test, exp.score, exp.row, exp.col, act.score, act.row, act.col);
            abort_run();
        end
    endtask

    task automatic compare_level(input string test, input string name,
                                 input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: %s expected %b, got %b", test, name, exp, act);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;     // inputs change just after the edge
    endtask

    function automatic sw_base_t base_code(input byte c);
        case (c)
            "C": return 2'd1;
            "G": return 2'd2;
            "T": return 2'd3;
            default: return 2'd0;
        endcase
    endfunction

    function automatic sw_job_t make_job(input string ref_s, input string read_s);
        sw_job_t job;
        job = '0;
        for (int k = 0; k < ref_s.len(); k++)
            job.ref_seq[REF_IDX_W'(REF_MAX_LEN - 1 - k)] = base_code(ref_s[k]);
        for (int k = 0; k < read_s.len(); k++)
            job.read_seq[READ_IDX_W'(READ_MAX_LEN - 1 - k)] = base_code(read_s[k]);
        job.ref_len = LEN_W'(ref_s.len());
        job.read_len = LEN_W'(read_s.len());
        return job;
    endfunction

    function automatic sw_result_t make_result(input int score, input int row, input int col);
        sw_result_t res;
        res.score = sw_score_t'(score);
        res.row = READ_IDX_W'(row);
        res.col = REF_IDX_W'(col);
        return res;
    endfunction

    task automatic send_job(input string test, input sw_job_t job);
        int waited;
        waited = 0;
        i_job = job;
        i_valid = 1'b1;
        while (o_ready !== 1'b1) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("%s: the DUT never became ready to take a job", test);
                abort_run();
            end
        end
        next_cycle();   // taken on this edge
        i_valid = 1'b0;
        compare_level(test, "o_ready", 1'b0, o_ready);
    endtask

    task automatic wait_result(input string test);
        int waited;
        waited = 0;
        while (o_valid !== 1'b1) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("%s: no result came out of the DUT in time", test);
                abort_run();
            end
        end
    endtask

    task automatic take_result(input string test);
        i_ready = 1'b1;
        next_cycle();
        compare_level(test, "o_valid", 1'b0, o_valid);
        compare_level(test, "o_ready", 1'b1, o_ready);
    endtask

    task automatic run_job(input string test, input sw_job_t job, input sw_result_t exp);
        send_job(test, job);
        wait_result(test);
        compare_result(test, exp, o_result);
        take_result(test);
    endtask

    task automatic test_reset_levels();
        compare_level("reset", "o_ready", 1'b1, o_ready);
        compare_level("reset", "o_valid", 1'b0, o_valid);
    endtask

    task automatic test_exact_match();
        run_job("identical", make_job("ACGTTGCAAGCTTCGA", "ACGTTGCAAGCTTCGA"),
                make_result(16, 15, 15));
        run_job("embedded", make_job("TTTTTGATCCATTTTT", "GATCCA"), make_result(6, 5, 10));
    endtask

    task automatic test_mismatch_and_gaps();
        sw_job_t job;
        job = make_job("ACGTACGTAC", "ACGTTCGTAC");
        run_job("mismatch", job, align_job(job));
        job = make_job("ACGTACCTGAGGCATT", "ACGTACCTAGGCATT");    // one base missing
        run_job("gap_1", job, align_job(job));
        job = make_job("CATGGACTTGCA", "CATGGATTTCTTGCA");       // three extra bases
        run_job("gap_3", job, align_job(job));
    endtask

    task automatic test_no_match_and_short();
        run_job("dissimilar", make_job("AAAAAAAA", "CCCCCC"), make_result(0, 0, 0));
        run_job("single_match", make_job("G", "G"), make_result(1, 0, 0));
        run_job("single_miss", make_job("G", "T"), make_result(0, 0, 0));
        run_job("single_read", make_job("AACAC", "C"), make_result(1, 0, 2));
    endtask

    task automatic test_back_pressure();
        sw_job_t    first;
        sw_job_t    second;
        sw_result_t exp;
        int         hold;
        first = make_job("CATGGACTTGCA", "ATGGACT");
        second = make_job("GGCATT", "GCAT");
        exp = align_job(first);
        hold = 2 + ($random(seed) & 15);
        i_ready = 1'b0;
        send_job("back_pressure", first);
        wait_result("back_pressure");
        i_job = second;     // offered while the result waits
        i_valid = 1'b1;
        repeat (hold) begin
            compare_level("back_pressure", "o_valid", 1'b1, o_valid);
            compare_level("back_pressure", "o_ready", 1'b0, o_ready);
            compare_result("back_pressure", exp, o_result);
            next_cycle();
        end
        compare_result("back_pressure", exp, o_result);
        take_result("back_pressure");
        run_job("back_pressure_next", second, align_job(second));
    endtask

    task automatic test_random_jobs();
        sw_job_t job;
        for (int n = 0; n < 50; n++) begin
            job = '0;
            job.ref_len = LEN_W'(1 + ($random(seed) & 15));
            job.read_len = LEN_W'(1 + ($random(seed) & 15));
            for (int k = 0; k < REF_MAX_LEN; k++) begin
                job.ref_seq[k] = sw_base_t'($random(seed));
                job.read_seq[k] = sw_base_t'($random(seed));
            end
            if (n % 2 == 1) begin   // near copy for high scores
                job.read_seq = job.ref_seq;
                job.read_seq[READ_IDX_W'($random(seed) & 15)] = sw_base_t'($random(seed));
                job.read_seq[READ_IDX_W'($random(seed) & 15)] = sw_base_t'($random(seed));
            end
            run_job($sformatf("random_%0d", n), job, align_job(job));
        end
    endtask

    initial begin
        seed = 97392;
        rst = 1'b1;
        i_valid = 1'b0;
        i_job = '0;
        i_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();
        test_reset_levels();
        test_exact_match();
        test_mismatch_and_gaps();
        test_no_match_and_short();
        test_back_pressure();
        test_random_jobs();
        $display("Everything OK");
        $finish;
    end

    `include "sw_ref_model.svh"

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+sim
src/sw_cfg_pkg.sv
src/sw_types_pkg.sv
src/sw_pe.sv
src/sw_pe_array.sv
src/sw_max_tracker.sv
src/sw_controller.sv
src/sw_top.sv
sim/tb_sw_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_sw_top -f filelist.f -o tb_sw_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sw_top
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
